// File: Makefile
SRCS := $(wildcard design/*.sv design/*.svh verif/*.sv)

all: run

obj_dir/Vtb_jvm_int_core: compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 -f compile.f \
		--top-module tb_jvm_int_core -Mdir obj_dir

run: obj_dir/Vtb_jvm_int_core
	./obj_dir/Vtb_jvm_int_core > sim.log 2>&1; rc=$$?; cat sim.log; \
		test $$rc -eq 0 && ! grep -q "SOME TESTS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: compile.f
+incdir+design
design/jvm_pkg.sv
design/alu.sv
design/bytecode_decoder.sv
design/uop_fifo.sv
design/stack_exec.sv
design/jvm_int_core.sv
verif/tb_jvm_int_core.sv

// File: design/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [31:0]      operand_a,
    input  logic [31:0]      operand_b,
    input  jvm_pkg::alu_op_t op_select,
    output logic [31:0]      result
);

    // operand_a is nos, operand_b is tos
    always_comb begin
        case (op_select)
            jvm_pkg::IADD: begin
                result = operand_a + operand_b;
            end
            // nos minus tos
            jvm_pkg::ISUB: begin
                result = operand_a - operand_b;
            end
            jvm_pkg::IAND: begin
                result = operand_a & operand_b;
            end
            jvm_pkg::IOR: begin
                result = operand_a | operand_b;
            end
            jvm_pkg::IXOR: begin
                result = operand_a ^ operand_b;
            end
            // bitwise complement only, not two's complement negate
            jvm_pkg::INEG: begin
                result = ~operand_a;
            end
            // shift count is the low 5 bits of tos
            jvm_pkg::ISHL: begin
                result = operand_a << operand_b[4:0];
            end
            // logical, zero fill
            jvm_pkg::ISHR: begin
                result = operand_a >> operand_b[4:0];
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: design/bytecode_decoder.sv
`timescale 1ns/1ns
`include "jvm_consts.svh"

module bytecode_decoder (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          bc_valid,
    input  logic [7:0]    bc_byte,
    output logic          uop_valid,
    output jvm_pkg::uop_t uop,
    output logic          bad_opcode
);

    // set after a bipush opcode and cleared by its operand byte
    logic          operand_pending;
    logic          dec_valid;
    logic          dec_bad;
    logic          dec_bipush;
    jvm_pkg::uop_t dec_uop;

    // alu op for arithmetic bytecodes
    function automatic jvm_pkg::alu_op_t bc_alu_op(input logic [7:0] b);
        case (b)
            `BC_ISUB:  return jvm_pkg::ISUB;
            `BC_INEG:  return jvm_pkg::INEG;
            `BC_ISHL:  return jvm_pkg::ISHL;
            `BC_IUSHR: return jvm_pkg::ISHR;
            `BC_IAND:  return jvm_pkg::IAND;
            `BC_IOR:   return jvm_pkg::IOR;
            `BC_IXOR:  return jvm_pkg::IXOR;
            default:   return jvm_pkg::IADD;
        endcase
    endfunction

    always_comb begin
        dec_valid  = 1'b0;
        dec_bad    = 1'b0;
        dec_bipush = 1'b0;
        dec_uop    = '0;
        if (bc_valid && operand_pending) begin
            // sign extended bipush operand
            dec_valid           = 1'b1;
            dec_uop.kind        = jvm_pkg::UOP_PUSH;
            dec_uop.payload.imm = {{24{bc_byte[7]}}, bc_byte};
        end else if (bc_valid) begin
            dec_valid = 1'b1;
            case (bc_byte) inside
                [`BC_ICONST_M1:`BC_ICONST_5]: begin
                    // opcode minus 3 gives -1 .. 5
                    dec_uop.kind        = jvm_pkg::UOP_PUSH;
                    dec_uop.payload.imm = 32'(bc_byte) - 32'd3;
                end
                `BC_BIPUSH: begin
                    // nothing to emit until the operand arrives
                    dec_valid  = 1'b0;
                    dec_bipush = 1'b1;
                end
                `BC_POP: dec_uop.kind = jvm_pkg::UOP_POP;
                `BC_DUP: dec_uop.kind = jvm_pkg::UOP_DUP;
                `BC_INEG: begin
                    dec_uop.kind           = jvm_pkg::UOP_UNARY;
                    dec_uop.payload.alu.op = bc_alu_op(bc_byte);
                end
                `BC_IADD, `BC_ISUB, `BC_ISHL, `BC_IUSHR, `BC_IAND, `BC_IOR, `BC_IXOR: begin
                    dec_uop.kind           = jvm_pkg::UOP_BINARY;
                    dec_uop.payload.alu.op = bc_alu_op(bc_byte);
                end
                default: begin
                    // unknown opcode is flagged and dropped
                    dec_valid = 1'b0;
                    dec_bad   = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop_valid       <= 1'b0;
            operand_pending <= 1'b0;
            bad_opcode      <= 1'b0;
        end else begin
            uop_valid <= dec_valid;
            if (bc_valid) begin
                operand_pending <= dec_bipush;
            end
            if (dec_bad) begin
                bad_opcode <= 1'b1;
            end
        end
    end

    // micro-op word qualified by uop_valid
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            uop <= dec_uop;
        end
    end

    // no micro-op leaves while a bipush operand is outstanding
    pending_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        operand_pending |-> !uop_valid);

endmodule

// File: design/jvm_consts.svh
`ifndef JVM_CONSTS_SVH
`define JVM_CONSTS_SVH

// operand stack size, tos and nos included
`define STACK_DEPTH     16
// micro-op queue entries
`define UOP_FIFO_DEPTH  4

// bytecode values
`define BC_ICONST_M1    8'h02
// iconst_0 .. iconst_4 sit between these two
`define BC_ICONST_5     8'h08
`define BC_BIPUSH       8'h10
`define BC_POP          8'h57
`define BC_DUP          8'h59
`define BC_IADD         8'h60
`define BC_ISUB         8'h64
`define BC_INEG         8'h74
`define BC_ISHL         8'h78
`define BC_IUSHR        8'h7c
`define BC_IAND         8'h7e
`define BC_IOR          8'h80
`define BC_IXOR         8'h82

`endif

// File: design/jvm_int_core.sv
`timescale 1ns/1ns

module jvm_int_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  bc_valid,
    input  logic [7:0]            bc_byte,
    output logic [31:0]           tos,
    output logic [4:0]            depth,
    output logic                  done,
    output jvm_pkg::core_faults_t faults
);

    // decoder to fifo
    logic          uop_valid;
    jvm_pkg::uop_t uop;
    // fifo to executor
    logic          not_empty;
    logic          pop;
    jvm_pkg::uop_t head;
    // sticky flags from each stage
    logic          bad_opcode;
    logic          fifo_overflow;
    logic          stack_overflow;
    logic          stack_underflow;

    bytecode_decoder dec0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .bc_valid   (bc_valid),
        .bc_byte    (bc_byte),
        .uop_valid  (uop_valid),
        .uop        (uop),
        .bad_opcode (bad_opcode)
    );

    uop_fifo fifo0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (uop_valid),
        .wr_data   (uop),
        .pop       (pop),
        .not_empty (not_empty),
        .head      (head),
        .overflow  (fifo_overflow)
    );

    stack_exec exec0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .not_empty       (not_empty),
        .head            (head),
        .pop             (pop),
        .tos             (tos),
        .depth           (depth),
        .done            (done),
        .stack_overflow  (stack_overflow),
        .stack_underflow (stack_underflow)
    );

    assign faults.bad_opcode      = bad_opcode;
    assign faults.fifo_overflow   = fifo_overflow;
    assign faults.stack_overflow  = stack_overflow;
    assign faults.stack_underflow = stack_underflow;

endmodule

// File: design/jvm_pkg.sv
package jvm_pkg;

    // alu op codes as the alu decodes them
    typedef enum logic [3:0] {
        IADD = 4'b0000,
        ISUB = 4'b0001,
        INEG = 4'b0101,
        ISHL = 4'b1100,
        // logical shift for iushr
        ISHR = 4'b1101,
        IAND = 4'b1111,
        IOR  = 4'b1000,
        IXOR = 4'b1001
    } alu_op_t;

    // what the executor does with a micro-op
    typedef enum logic [2:0] {
        UOP_PUSH,
        UOP_POP,
        UOP_DUP,
        UOP_UNARY,
        UOP_BINARY
    } uop_kind_t;

    // imm for pushes and the alu view for unary and binary ops
    typedef union packed {
        logic [31:0] imm;
        struct packed {
            logic [27:0] pad;
            alu_op_t     op;
        } alu;
    } uop_payload_u;

    typedef struct packed {
        uop_kind_t    kind;
        uop_payload_u payload;
    } uop_t;

    // sticky error flags seen at the core boundary
    typedef struct packed {
        logic bad_opcode;
        logic fifo_overflow;
        logic stack_overflow;
        logic stack_underflow;
    } core_faults_t;

endpackage

// File: design/stack_exec.sv
`timescale 1ns/1ns
`include "jvm_consts.svh"

module stack_exec (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          not_empty,
    input  jvm_pkg::uop_t head,
    output logic          pop,
    output logic [31:0]   tos,
    output logic [4:0]    depth,
    output logic          done,
    output logic          stack_overflow,
    output logic          stack_underflow
);

    localparam int RAM_DEPTH = `STACK_DEPTH - 2;
    localparam int AW        = $clog2(RAM_DEPTH);

    // entries below nos, slot 0 is the bottom of the stack
    logic [31:0]   ram [RAM_DEPTH];
    logic [31:0]   nos;
    logic [31:0]   rd_q;
    logic [AW-1:0] rd_addr;
    logic [AW-1:0] ram_waddr;
    logic          ram_we;
    logic [31:0]   tos_d;
    logic [31:0]   nos_d;
    logic [4:0]    depth_d;
    logic [31:0]   alu_a;
    logic [31:0]   alu_result;
    // second cycle of a binary op
    logic          busy;
    logic          busy_d;
    logic          done_d;
    logic          full;
    logic          ovf_set;
    logic          unf_set;

    assign full = depth == 5'(`STACK_DEPTH);
    // unary ops work on tos alone
    assign alu_a = (head.kind == jvm_pkg::UOP_UNARY) ? tos : nos;

    alu alu0 (
        .operand_a (alu_a),
        .operand_b (tos),
        .op_select (head.payload.alu.op),
        .result    (alu_result)
    );

    always_comb begin
        pop     = 1'b0;
        tos_d   = tos;
        nos_d   = nos;
        depth_d = depth;
        busy_d  = 1'b0;
        done_d  = 1'b0;
        ram_we  = 1'b0;
        ovf_set = 1'b0;
        unf_set = 1'b0;
        if (busy) begin
            // refill nos from the read issued last cycle
            nos_d   = rd_q;
            depth_d = depth - 5'd1;
            done_d  = 1'b1;
        end else if (not_empty) begin
            pop    = 1'b1;
            done_d = 1'b1;
            case (head.kind)
                jvm_pkg::UOP_PUSH: begin
                    if (full) begin
                        ovf_set = 1'b1;
                    end else begin
                        tos_d   = head.payload.imm;
                        nos_d   = tos;
                        ram_we  = depth >= 5'd2;
                        depth_d = depth + 5'd1;
                    end
                end
                jvm_pkg::UOP_DUP: begin
                    if (depth == 5'd0) begin
                        unf_set = 1'b1;
                    end else if (full) begin
                        ovf_set = 1'b1;
                    end else begin
                        nos_d   = tos;
                        ram_we  = depth >= 5'd2;
                        depth_d = depth + 5'd1;
                    end
                end
                jvm_pkg::UOP_POP: begin
                    if (depth == 5'd0) begin
                        unf_set = 1'b1;
                    end else begin
                        tos_d   = nos;
                        nos_d   = rd_q;
                        depth_d = depth - 5'd1;
                    end
                end
                jvm_pkg::UOP_UNARY: begin
                    if (depth == 5'd0) begin
                        unf_set = 1'b1;
                    end else begin
                        tos_d = alu_result;
                    end
                end
                jvm_pkg::UOP_BINARY: begin
                    if (depth < 5'd2) begin
                        unf_set = 1'b1;
                    end else begin
                        // result now, nos refill and depth next cycle
                        tos_d  = alu_result;
                        busy_d = 1'b1;
                        done_d = 1'b0;
                    end
                end
                default: begin
                    done_d = 1'b1;
                end
            endcase
        end
    end

    // spill target is the slot just below the old nos
    assign ram_waddr = AW'(depth - 5'd2);
    // read port tracks the entry below nos of the next state
    assign rd_addr = (depth_d >= 5'd3) ? AW'(depth_d - 5'd3) : '0;

    always_ff @(posedge clk) begin
        if (ram_we) begin
            ram[ram_waddr] <= nos;
        end
        // forward a spill that lands on the slot being read
        rd_q <= (ram_we && ram_waddr == rd_addr) ? nos : ram[rd_addr];
        tos  <= tos_d;
        nos  <= nos_d;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            depth           <= '0;
            busy            <= 1'b0;
            done            <= 1'b0;
            stack_overflow  <= 1'b0;
            stack_underflow <= 1'b0;
        end else begin
            depth <= depth_d;
            busy  <= busy_d;
            done  <= done_d;
            if (ovf_set) begin
                stack_overflow <= 1'b1;
            end
            if (unf_set) begin
                stack_underflow <= 1'b1;
            end
        end
    end

    depth_bound: assert property (@(posedge clk) disable iff (!rst_n)
        depth <= 5'(`STACK_DEPTH));

endmodule

// File: design/uop_fifo.sv
`timescale 1ns/1ns
`include "jvm_consts.svh"

module uop_fifo (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          wr,
    input  jvm_pkg::uop_t wr_data,
    input  logic          pop,
    output logic          not_empty,
    output jvm_pkg::uop_t head,
    output logic          overflow
);

    localparam int DEPTH = `UOP_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    jvm_pkg::uop_t    mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // one extra bit so a full queue is representable
    logic [PTR_W:0]   count;
    logic             full;
    logic             do_wr;
    logic             do_pop;

    assign full      = count == (PTR_W+1)'(DEPTH);
    assign not_empty = count != '0;
    // full drops the write even if a pop happens alongside
    assign do_wr     = wr && !full;
    assign do_pop    = pop && not_empty;
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                // wrap for any depth, not only powers of two
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (PTR_W+1)'(do_wr) - (PTR_W+1)'(do_pop);
            // sticky until reset
            if (wr && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // executor must only pop a head it can see
    pop_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> not_empty);

endmodule

// File: verif/tb_jvm_int_core.sv
`timescale 1ns/1ns
`include "jvm_consts.svh"

module tb_jvm_int_core;

    // limit well above the roughly 600 cycles the tests take
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int DONE_WAIT      = 20;

    logic                  clk;
    logic                  rst_n;
    logic                  bc_valid;
    logic [7:0]            bc_byte;
    logic [31:0]           tos;
    logic [4:0]            depth;
    logic                  done;
    jvm_pkg::core_faults_t faults;

    // expected stack with the top at the back of the queue
    logic [31:0] model [$];
    logic [31:0] lcg_state;
    int          cycle_count;
    int          check_count;
    int          error_count;

    jvm_int_core dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .bc_valid (bc_valid),
        .bc_byte  (bc_byte),
        .tos      (tos),
        .depth    (depth),
        .done     (done),
        .faults   (faults)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // upper bits of the lcg are the better ones
    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = lcg_next();
        return r[23:16];
    endfunction

    function automatic logic [31:0] sext8(input logic [7:0] b);
        return {{24{b[7]}}, b};
    endfunction

    // jvm semantics with a as the deeper operand
    function automatic logic [31:0] binary_result(input logic [7:0] op,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b);
        case (op)
            `BC_IADD:  return a + b;
            `BC_ISUB:  return a - b;
            `BC_IAND:  return a & b;
            `BC_IOR:   return a | b;
            `BC_IXOR:  return a ^ b;
            // shift count taken mod 32
            `BC_ISHL:  return a << b[4:0];
            `BC_IUSHR: return a >> b[4:0];
            default:   return 32'h0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("** Error @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_stack();
        check_value("depth", 32'(depth), 32'(model.size()));
        // tos only means something with an entry on the stack
        if (model.size() > 0) begin
            check_value("tos", tos, model[$]);
        end
    endtask

    task automatic reset_dut();
        rst_n    = 1'b0;
        bc_valid = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        model.delete();
    endtask

    // one strobe followed by one idle cycle
    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        #1;
        bc_valid = 1'b1;
        bc_byte  = b;
        @(posedge clk);
        #1;
        bc_valid = 1'b0;
    endtask

    // strobes on consecutive cycles
    task automatic send_burst(input logic [7:0] b, input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            bc_valid = 1'b1;
            bc_byte  = b;
        end
        @(posedge clk);
        #1;
        bc_valid = 1'b0;
    endtask

    // done sampled at the falling edge
    task automatic wait_for_done(output logic seen);
        seen = 1'b0;
        for (int i = 0; i < DONE_WAIT && !seen; i++) begin
            @(negedge clk);
            seen = done;
        end
    endtask

    task automatic expect_done(input string what);
        logic seen;
        wait_for_done(seen);
        check_count++;
        assert (seen) else begin
            error_count++;
            $display("no done within %0d cycles after %s at %0t", DONE_WAIT, what, $time);
        end
    endtask

    task automatic expect_no_done(input string what);
        logic seen;
        wait_for_done(seen);
        check_count++;
        assert (!seen) else begin
            error_count++;
            $display("done pulsed after %s at %0t, none was expected", what, $time);
        end
    endtask

    task automatic push_imm(input logic [7:0] v);
        send_byte(`BC_BIPUSH);
        send_byte(v);
        expect_done("bipush");
        model.push_back(sext8(v));
        check_stack();
    endtask

    task automatic test_reset_state();
        check_stack();
        check_value("faults", 32'(faults), 32'h0);
        repeat (10) begin
            @(negedge clk);
            check_value("done while idle", 32'(done), 32'h0);
        end
    endtask

    task automatic test_pushes();
        logic [7:0] b;
        // iconst_m1 pushes -1 and each following opcode one more
        for (int i = 0; i < 7; i++) begin
            b = `BC_ICONST_M1 + 8'(i);
            send_byte(b);
            expect_done("iconst");
            model.push_back(32'(i - 1));
            check_stack();
        end
        push_imm(8'h9c);
        repeat (4) push_imm(rand_byte());
        check_value("faults after pushes", 32'(faults), 32'h0);
    endtask

    task automatic test_binary_ops();
        logic [7:0]  ops [7];
        logic [31:0] a;
        logic [31:0] b;
        ops = '{`BC_IADD, `BC_ISUB, `BC_IAND, `BC_IOR, `BC_IXOR, `BC_ISHL, `BC_IUSHR};
        reset_dut();
        // each op leaves one entry so later ops refill nos from the ram
        foreach (ops[i]) begin
            push_imm(rand_byte());
            push_imm(rand_byte());
            send_byte(ops[i]);
            expect_done("binary op");
            b = model.pop_back();
            a = model.pop_back();
            model.push_back(binary_result(ops[i], a, b));
            check_stack();
        end
        check_value("faults after binary ops", 32'(faults), 32'h0);
    endtask

    task automatic test_stack_ops();
        logic [31:0] v;
        reset_dut();
        push_imm(rand_byte());
        push_imm(rand_byte());
        // ineg is a plain complement in this core
        send_byte(`BC_INEG);
        expect_done("ineg");
        v = model.pop_back();
        model.push_back(~v);
        check_stack();
        send_byte(`BC_DUP);
        expect_done("dup");
        model.push_back(model[$]);
        check_stack();
        send_byte(`BC_POP);
        expect_done("pop");
        v = model.pop_back();
        check_stack();
        while (model.size() < `STACK_DEPTH) begin
            push_imm(rand_byte());
        end
        check_value("faults before overflow", 32'(faults), 32'h0);
        // one push too many
        send_byte(`BC_BIPUSH);
        send_byte(8'h11);
        expect_done("push on full stack");
        check_value("stack_overflow", 32'(faults.stack_overflow), 32'h1);
        check_stack();
        // unwind through the ram
        while (model.size() > 0) begin
            send_byte(`BC_POP);
            expect_done("pop");
            v = model.pop_back();
            check_stack();
        end
    endtask

    task automatic test_faults();
        reset_dut();
        push_imm(rand_byte());
        check_value("faults before underflow", 32'(faults), 32'h0);
        send_byte(`BC_IADD);
        expect_done("iadd with one entry");
        check_value("stack_underflow", 32'(faults.stack_underflow), 32'h1);
        check_stack();
        check_value("bad_opcode before", 32'(faults.bad_opcode), 32'h0);
        send_byte(8'hff);
        expect_no_done("undefined opcode");
        check_value("bad_opcode", 32'(faults.bad_opcode), 32'h1);
        check_stack();
    endtask

    task automatic test_fifo_overflow();
        reset_dut();
        // enough entries that the burst runs real two-cycle adds
        repeat (12) begin
            send_byte(`BC_ICONST_M1 + 8'd2);
            expect_done("iconst_1");
            model.push_back(32'd1);
            check_stack();
        end
        check_value("faults before burst", 32'(faults), 32'h0);
        send_burst(`BC_IADD, 4 * `UOP_FIFO_DEPTH);
        repeat (60) @(negedge clk);
        check_value("fifo_overflow", 32'(faults.fifo_overflow), 32'h1);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        bc_valid    = 1'b0;
        bc_byte     = 8'h00;
        lcg_state   = 32'd51019;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        reset_dut();
        test_reset_state();
        test_pushes();
        test_binary_ops();
        test_stack_ops();
        test_faults();
        test_fifo_overflow();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
